/* dma_pkg.sv */
/* Widths, register map, address map and transfer structs shared by the 2D copy DMA.
   Every RTL module pulls these in with a wildcard import in its header. */
package dma_pkg;

  // Widths
  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned LEN_W     = 16;
  localparam int unsigned REG_IDX_W = 4;

  // Global request queue
  localparam int unsigned QUEUE_DEPTH = 4;
  localparam int unsigned QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int unsigned QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

  // Address map, everything outside the TCDM window is external
  localparam logic [ADDR_W-1:0] TCDM_BASE  = 32'h1C00_0000;
  localparam logic [ADDR_W-1:0] TCDM_SIZE  = 32'h0001_0000;
  localparam logic [ADDR_W-1:0] WORD_BYTES = ADDR_W'(DATA_W / 8);

  // ------------------------------
  // Register map, one word each
  // ------------------------------
  localparam logic [REG_IDX_W-1:0] REG_SRC        = 4'd0;
  localparam logic [REG_IDX_W-1:0] REG_DST        = 4'd1;
  localparam logic [REG_IDX_W-1:0] REG_LEN        = 4'd2;
  localparam logic [REG_IDX_W-1:0] REG_SRC_STRIDE = 4'd3;
  localparam logic [REG_IDX_W-1:0] REG_DST_STRIDE = 4'd4;
  localparam logic [REG_IDX_W-1:0] REG_REPS       = 4'd5;
  localparam logic [REG_IDX_W-1:0] REG_CONF       = 4'd6;
  localparam logic [REG_IDX_W-1:0] REG_NEXT_ID    = 4'd7;
  localparam logic [REG_IDX_W-1:0] REG_DONE_ID    = 4'd8;
  localparam logic [REG_IDX_W-1:0] REG_STATUS     = 4'd9;

  // ------------------------------
  // Transfer structs
  // ------------------------------
  typedef struct packed {
    logic                 valid;
    logic                 write;
    logic [REG_IDX_W-1:0] index;
    logic [DATA_W-1:0]    wdata;
  } reg_req_t;

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] rdata;
  } reg_rsp_t;

  typedef struct packed {
    logic [ADDR_W-1:0] src;
    logic [ADDR_W-1:0] dst;
    logic [LEN_W-1:0]  len;
  } burst_req_t;

  typedef struct packed {
    burst_req_t        burst;
    logic [ADDR_W-1:0] src_stride;
    logic [ADDR_W-1:0] dst_stride;
    logic [DATA_W-1:0] reps;
    logic              is_2d;
  } nd_req_t;

  // One read and one write per cycle
  typedef struct packed {
    logic              rd_valid;
    logic [ADDR_W-1:0] rd_addr;
    logic              wr_valid;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
  } mem_req_t;

endpackage

/* dma_reg_frontend.sv */
/* Register file of the DMA. Builds a transfer descriptor from the written registers,
   launches it on a read of the launch register and counts finished transfers. */
`timescale 1ns/1ns

module dma_reg_frontend import dma_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  output nd_req_t  nd_req_o,
  output logic     nd_valid_o,
  input  logic     nd_ready_i,
  input  logic     trans_done_i,
  input  logic     busy_i
);

  logic [DATA_W-1:0] src_q, dst_q, len_q;
  logic [DATA_W-1:0] src_stride_q, dst_stride_q, reps_q, conf_q;
  logic [DATA_W-1:0] next_id_q, done_id_q;
  logic [DATA_W-1:0] rdata_d;
  logic              wr_en, rd_en;

  assign wr_en = reg_req_i.valid && reg_req_i.write;
  assign rd_en = reg_req_i.valid && !reg_req_i.write;

  // Launch is a read of the next ID register
  assign nd_valid_o = rd_en && (reg_req_i.index == REG_NEXT_ID);

  assign nd_req_o.burst.src  = src_q;
  assign nd_req_o.burst.dst  = dst_q;
  assign nd_req_o.burst.len  = len_q[LEN_W-1:0];
  assign nd_req_o.src_stride = src_stride_q;
  assign nd_req_o.dst_stride = dst_stride_q;
  assign nd_req_o.reps       = reps_q;
  assign nd_req_o.is_2d      = conf_q[0];

  // ------------------------------
  // Descriptor registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      src_q        <= '0;
      dst_q        <= '0;
      len_q        <= '0;
      src_stride_q <= '0;
      dst_stride_q <= '0;
      reps_q       <= '0;
      conf_q       <= '0;
    end else if (wr_en) begin
      case (reg_req_i.index)
        REG_SRC:        src_q        <= reg_req_i.wdata;
        REG_DST:        dst_q        <= reg_req_i.wdata;
        REG_LEN:        len_q        <= reg_req_i.wdata;
        REG_SRC_STRIDE: src_stride_q <= reg_req_i.wdata;
        REG_DST_STRIDE: dst_stride_q <= reg_req_i.wdata;
        REG_REPS:       reps_q       <= reg_req_i.wdata;
        REG_CONF:       conf_q       <= reg_req_i.wdata;
        default:        ;
      endcase
    end
  end

  // Read mux, a refused launch answers 0
  always_comb begin
    case (reg_req_i.index)
      REG_SRC:        rdata_d = src_q;
      REG_DST:        rdata_d = dst_q;
      REG_LEN:        rdata_d = len_q;
      REG_SRC_STRIDE: rdata_d = src_stride_q;
      REG_DST_STRIDE: rdata_d = dst_stride_q;
      REG_REPS:       rdata_d = reps_q;
      REG_CONF:       rdata_d = conf_q;
      REG_NEXT_ID:    rdata_d = nd_ready_i ? next_id_q + DATA_W'(1) : '0;
      REG_DONE_ID:    rdata_d = done_id_q;
      REG_STATUS:     rdata_d = {{(DATA_W-1){1'b0}}, busy_i};
      default:        rdata_d = '0;
    endcase
  end

  // ------------------------------
  // ID counters and response
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      next_id_q <= '0;
      done_id_q <= '0;
      reg_rsp_o <= '0;
    end else begin
      if (nd_valid_o && nd_ready_i) begin
        next_id_q <= next_id_q + DATA_W'(1);
      end
      if (trans_done_i) begin
        done_id_q <= done_id_q + DATA_W'(1);
      end
      reg_rsp_o.valid <= rd_en;
      reg_rsp_o.rdata <= rd_en ? rdata_d : '0;
    end
  end

endmodule

/* dma_req_queue.sv */
/* Global request queue between the register frontend and the 2D midend.
   Circular buffer with valid/ready on both sides, no fall-through. */
`timescale 1ns/1ns

module dma_req_queue import dma_pkg::*; (
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  nd_req_t in_req_i,
  input  logic    in_valid_i,
  output logic    in_ready_o,
  output nd_req_t out_req_o,
  output logic    out_valid_o,
  input  logic    out_ready_i,
  output logic    not_empty_o
);

  nd_req_t                mem_q [QUEUE_DEPTH];
  logic [QUEUE_PTR_W-1:0] wptr_q, rptr_q;
  logic [QUEUE_CNT_W-1:0] count_q;
  logic                   push, pop;

  assign in_ready_o  = count_q != QUEUE_CNT_W'(QUEUE_DEPTH);
  assign out_valid_o = count_q != '0;
  assign not_empty_o = out_valid_o;
  assign out_req_o   = mem_q[rptr_q];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  // Pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= wptr_q + QUEUE_PTR_W'(1);
      end
      if (pop) begin
        rptr_q <= rptr_q + QUEUE_PTR_W'(1);
      end
      if (push && !pop) begin
        count_q <= count_q + QUEUE_CNT_W'(1);
      end else if (pop && !push) begin
        count_q <= count_q - QUEUE_CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= in_req_i;
    end
  end

endmodule

/* dma_twod_midend.sv */
/* 2D midend. Takes one descriptor at a time, hands out strided linear bursts to the
   backend and pulses trans_done_o once every burst of the descriptor has finished. */
`timescale 1ns/1ns

module dma_twod_midend import dma_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  nd_req_t    nd_req_i,
  input  logic       nd_valid_i,
  output logic       nd_ready_o,
  output burst_req_t burst_o,
  output logic       burst_valid_o,
  input  logic       burst_ready_i,
  input  logic       burst_done_i,
  output logic       trans_done_o,
  output logic       busy_o
);

  logic              active_q;
  logic [DATA_W-1:0] total_q, issued_q, finished_q;
  logic [ADDR_W-1:0] cur_src_q, cur_dst_q;
  logic [ADDR_W-1:0] src_stride_q, dst_stride_q;
  logic [LEN_W-1:0]  len_q;
  logic              accept, issue;

  assign nd_ready_o    = !active_q;
  assign accept        = nd_valid_i && nd_ready_o;
  assign burst_valid_o = active_q && (issued_q != total_q);
  assign issue         = burst_valid_o && burst_ready_i;

  // Also covers reps 0, where nothing is issued at all
  assign trans_done_o = active_q && (finished_q == total_q);
  assign busy_o       = active_q;

  assign burst_o.src = cur_src_q;
  assign burst_o.dst = cur_dst_q;
  assign burst_o.len = len_q;

  // ------------------------------
  // Burst bookkeeping
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q   <= 1'b0;
      total_q    <= '0;
      issued_q   <= '0;
      finished_q <= '0;
    end else if (accept) begin
      active_q   <= 1'b1;
      total_q    <= nd_req_i.is_2d ? nd_req_i.reps : DATA_W'(1);
      issued_q   <= '0;
      finished_q <= '0;
    end else begin
      if (trans_done_o) begin
        active_q <= 1'b0;
      end
      if (issue) begin
        issued_q <= issued_q + DATA_W'(1);
      end
      if (burst_done_i) begin
        finished_q <= finished_q + DATA_W'(1);
      end
    end
  end

  // Current addresses step by the strides after every issued burst
  always_ff @(posedge clk_i) begin
    if (accept) begin
      cur_src_q    <= nd_req_i.burst.src;
      cur_dst_q    <= nd_req_i.burst.dst;
      len_q        <= nd_req_i.burst.len;
      src_stride_q <= nd_req_i.src_stride;
      dst_stride_q <= nd_req_i.dst_stride;
    end else if (issue) begin
      cur_src_q <= cur_src_q + src_stride_q;
      cur_dst_q <= cur_dst_q + dst_stride_q;
    end
  end

endmodule

/* dma_copy_backend.sv */
/* Copy backend. Reads a linear burst word by word and writes each word one cycle later,
   so one read and one write are in flight together. Pulses burst_done_o per burst. */
`timescale 1ns/1ns

module dma_copy_backend import dma_pkg::*; (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  burst_req_t        burst_i,
  input  logic              burst_valid_i,
  output logic              burst_ready_o,
  output mem_req_t          mem_req_o,
  input  logic [DATA_W-1:0] rd_data_i,
  output logic              burst_done_o,
  output logic              busy_o
);

  logic              busy_q, done_q, wr_valid_q;
  logic [LEN_W-1:0]  rd_left_q;
  logic [ADDR_W-1:0] rd_addr_q, wr_addr_q;
  logic              accept, start, rd_run, rd_valid;

  assign burst_ready_o = !busy_q;
  assign accept        = burst_valid_i && burst_ready_o;

  // Zero-length bursts are accepted but never touch memory
  assign start    = accept && (burst_i.len != '0);
  assign rd_run   = busy_q && (rd_left_q != '0);
  assign rd_valid = start || rd_run;

  // First read goes out in the acceptance cycle
  assign mem_req_o.rd_valid = rd_valid;
  assign mem_req_o.rd_addr  = start ? burst_i.src : rd_addr_q;

  // Read data returns one cycle later and is written straight away
  assign mem_req_o.wr_valid = wr_valid_q;
  assign mem_req_o.wr_addr  = wr_addr_q;
  assign mem_req_o.wr_data  = rd_data_i;

  assign burst_done_o = done_q;
  assign busy_o       = busy_q;

  // ------------------------------
  // Control
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      wr_valid_q <= 1'b0;
      rd_left_q  <= '0;
    end else begin
      if (accept) begin
        busy_q <= 1'b1;
      end else if (done_q) begin
        busy_q <= 1'b0;
      end
      wr_valid_q <= rd_valid;
      // Last write without a read behind it ends the burst
      done_q <= (accept && (burst_i.len == '0)) || (wr_valid_q && !rd_valid);
      if (start) begin
        rd_left_q <= burst_i.len - LEN_W'(1);
      end else if (rd_run) begin
        rd_left_q <= rd_left_q - LEN_W'(1);
      end
    end
  end

  // Address counters
  always_ff @(posedge clk_i) begin
    if (start) begin
      rd_addr_q <= burst_i.src + WORD_BYTES;
    end else if (rd_run) begin
      rd_addr_q <= rd_addr_q + WORD_BYTES;
    end
    if (start) begin
      wr_addr_q <= burst_i.dst;
    end else if (wr_valid_q) begin
      wr_addr_q <= wr_addr_q + WORD_BYTES;
    end
  end

endmodule

/* dma_addr_decoder.sv */
/* Address decoder between the backend and the two memory ports. Reads and writes are
   routed on their own address, so one copy may read TCDM and write external memory. */
`timescale 1ns/1ns

module dma_addr_decoder import dma_pkg::*; (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  mem_req_t          mem_req_i,
  output logic [DATA_W-1:0] rd_data_o,
  output mem_req_t          tcdm_req_o,
  input  logic [DATA_W-1:0] tcdm_rd_data_i,
  output mem_req_t          ext_req_o,
  input  logic [DATA_W-1:0] ext_rd_data_i
);

  logic rd_tcdm, wr_tcdm, rd_tcdm_q;

  function automatic logic in_tcdm(input logic [ADDR_W-1:0] addr);
    return (addr >= TCDM_BASE) && (addr < TCDM_BASE + TCDM_SIZE);
  endfunction

  assign rd_tcdm = in_tcdm(mem_req_i.rd_addr);
  assign wr_tcdm = in_tcdm(mem_req_i.wr_addr);

  // Addresses and data fan out, only the strobes are steered
  always_comb begin
    tcdm_req_o          = mem_req_i;
    tcdm_req_o.rd_valid = mem_req_i.rd_valid && rd_tcdm;
    tcdm_req_o.wr_valid = mem_req_i.wr_valid && wr_tcdm;
    ext_req_o           = mem_req_i;
    ext_req_o.rd_valid  = mem_req_i.rd_valid && !rd_tcdm;
    ext_req_o.wr_valid  = mem_req_i.wr_valid && !wr_tcdm;
  end

  // Remember which port answers next cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_tcdm_q <= 1'b0;
    end else if (mem_req_i.rd_valid) begin
      rd_tcdm_q <= rd_tcdm;
    end
  end

  assign rd_data_o = rd_tcdm_q ? tcdm_rd_data_i : ext_rd_data_i;

endmodule

/* dma_top.sv */
/* Top level of the 2D copy DMA. Chains frontend, request queue, midend, backend and
   address decoder, and drives the completion event and the busy flag. */
`timescale 1ns/1ns

module dma_top import dma_pkg::*; (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  reg_req_t          reg_req_i,
  output reg_rsp_t          reg_rsp_o,
  output mem_req_t          tcdm_req_o,
  input  logic [DATA_W-1:0] tcdm_rd_data_i,
  output mem_req_t          ext_req_o,
  input  logic [DATA_W-1:0] ext_rd_data_i,
  output logic              term_event_o,
  output logic              busy_o
);

  nd_req_t           fe_req, queue_req;
  burst_req_t        burst_req;
  mem_req_t          be_mem_req;
  logic [DATA_W-1:0] be_rd_data;
  logic fe_valid, fe_ready, queue_valid, queue_ready, queue_not_empty;
  logic be_valid, be_ready, burst_done, trans_done;
  logic midend_busy, backend_busy;

  dma_reg_frontend i_reg_frontend (
    .clk_i, .arst_n_i, .reg_req_i, .reg_rsp_o,
    .nd_req_o     ( fe_req     ),
    .nd_valid_o   ( fe_valid   ),
    .nd_ready_i   ( fe_ready   ),
    .trans_done_i ( trans_done ),
    .busy_i       ( busy_o     )
  );

  dma_req_queue i_req_queue (
    .clk_i, .arst_n_i,
    .in_req_i    ( fe_req          ),
    .in_valid_i  ( fe_valid        ),
    .in_ready_o  ( fe_ready        ),
    .out_req_o   ( queue_req       ),
    .out_valid_o ( queue_valid     ),
    .out_ready_i ( queue_ready     ),
    .not_empty_o ( queue_not_empty )
  );

  dma_twod_midend i_twod_midend (
    .clk_i, .arst_n_i,
    .nd_req_i ( queue_req ), .nd_valid_i ( queue_valid ), .nd_ready_o ( queue_ready ),
    .burst_o  ( burst_req ), .burst_valid_o ( be_valid ), .burst_ready_i ( be_ready ),
    .burst_done_i ( burst_done  ),
    .trans_done_o ( trans_done  ),
    .busy_o       ( midend_busy )
  );

  dma_copy_backend i_copy_backend (
    .clk_i, .arst_n_i,
    .burst_i ( burst_req ), .burst_valid_i ( be_valid ), .burst_ready_o ( be_ready ),
    .mem_req_o    ( be_mem_req   ),
    .rd_data_i    ( be_rd_data   ),
    .burst_done_o ( burst_done   ),
    .busy_o       ( backend_busy )
  );

  dma_addr_decoder i_addr_decoder (
    .clk_i, .arst_n_i, .tcdm_req_o, .tcdm_rd_data_i, .ext_req_o, .ext_rd_data_i,
    .mem_req_i ( be_mem_req ),
    .rd_data_o ( be_rd_data )
  );

  // Completion event, one cycle behind the midend
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      term_event_o <= 1'b0;
    end else begin
      term_event_o <= trans_done;
    end
  end

  assign busy_o = queue_not_empty | midend_busy | backend_busy;

endmodule

/* tb_dma_top.sv */
/* Testbench for the 2D copy DMA. Models the TCDM and external memories, programs
   transfers through the register port and checks copies, IDs and flags with assertions. */
`timescale 1ns/1ns

module tb_dma_top import dma_pkg::*; ();

  // Longest phase is the queue fill with five 64-word copies of about 70 cycles each
  localparam int MAX_CYCLES = 20000;

  localparam logic [31:0] EXT_A  = 32'h8000_0000;
  localparam logic [31:0] EXT_B  = 32'h8001_0000;
  localparam logic [31:0] EXT_C  = 32'h8003_0000;
  localparam logic [31:0] EXT_D  = 32'h8002_0000;
  localparam logic [31:0] TCDM_A = TCDM_BASE + 32'h0000_0100;
  localparam logic [31:0] TCDM_B = TCDM_BASE + 32'h0000_1000;
  localparam logic [31:0] TCDM_C = TCDM_BASE + 32'h0000_2000;

  logic              clk;
  logic              arst_n;
  reg_req_t          reg_req;
  reg_rsp_t          reg_rsp;
  mem_req_t          tcdm_req;
  mem_req_t          ext_req;
  logic [DATA_W-1:0] tcdm_rd_data;
  logic [DATA_W-1:0] ext_rd_data;
  logic              term_event;
  logic              busy;

  logic [31:0] tcdm_mem [logic [31:0]];
  logic [31:0] ext_mem [logic [31:0]];
  logic [31:0] lfsr_state = 32'd81;
  int          checks = 0;
  int          errors = 0;
  int          cycles = 0;
  int          term_count = 0;
  int          wr_count = 0;

  dma_top dma_top_i (
    .clk_i          ( clk          ),
    .arst_n_i       ( arst_n       ),
    .reg_req_i      ( reg_req      ),
    .reg_rsp_o      ( reg_rsp      ),
    .tcdm_req_o     ( tcdm_req     ),
    .tcdm_rd_data_i ( tcdm_rd_data ),
    .ext_req_o      ( ext_req      ),
    .ext_rd_data_i  ( ext_rd_data  ),
    .term_event_o   ( term_event   ),
    .busy_o         ( busy         )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  // One LFSR step per bit
  task automatic rand_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return {a[15:0], a[31:16]} ^ 32'hC3A5_5A3C;
  endfunction

  function automatic logic [31:0] mem_word(input logic is_tcdm, input logic [31:0] a);
    if (is_tcdm) begin
      return tcdm_mem.exists(a) ? tcdm_mem[a] : fill_word(a);
    end
    return ext_mem.exists(a) ? ext_mem[a] : fill_word(a);
  endfunction

  task automatic preload(input logic is_tcdm, input logic [31:0] base, input int words);
    logic [31:0] w;
    for (int i = 0; i < words; i++) begin
      rand_word(w);
      if (is_tcdm) tcdm_mem[base + 32'(4 * i)] = w;
      else ext_mem[base + 32'(4 * i)] = w;
    end
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic wait_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic reg_write(input logic [REG_IDX_W-1:0] idx, input logic [31:0] data);
    reg_req.valid = 1'b1;
    reg_req.write = 1'b1;
    reg_req.index = idx;
    reg_req.wdata = data;
    wait_cycle();
    reg_req = '0;
  endtask

  task automatic reg_read(input logic [REG_IDX_W-1:0] idx, output logic [31:0] data);
    reg_req.valid = 1'b1;
    reg_req.write = 1'b0;
    reg_req.index = idx;
    reg_req.wdata = '0;
    wait_cycle();
    reg_req = '0;
    checks++;
    assert (reg_rsp.valid) else begin
      errors++;
      $display("Register read of index %0d got no response", idx);
    end
    data = reg_rsp.rdata;
  endtask

  task automatic set_desc(input logic [31:0] src, input logic [31:0] dst,
                          input logic [31:0] len, input logic [31:0] src_stride,
                          input logic [31:0] dst_stride, input logic [31:0] reps,
                          input logic [31:0] conf);
    reg_write(REG_SRC, src);
    reg_write(REG_DST, dst);
    reg_write(REG_LEN, len);
    reg_write(REG_SRC_STRIDE, src_stride);
    reg_write(REG_DST_STRIDE, dst_stride);
    reg_write(REG_REPS, reps);
    reg_write(REG_CONF, conf);
  endtask

  task automatic wait_terms(input int target);
    while (term_count < target) wait_cycle();
  endtask

  task finish_run();
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  // ------------------------------
  // Memory models and monitors
  // ------------------------------
  always @(posedge clk) begin
    logic [31:0] tcdm_word;
    logic [31:0] ext_word;
    tcdm_word = tcdm_req.rd_valid ? mem_word(1'b1, tcdm_req.rd_addr) : '0;
    ext_word  = ext_req.rd_valid ? mem_word(1'b0, ext_req.rd_addr) : '0;
    if (tcdm_req.wr_valid) begin
      tcdm_mem[tcdm_req.wr_addr] = tcdm_req.wr_data;
      wr_count++;
    end
    if (ext_req.wr_valid) begin
      ext_mem[ext_req.wr_addr] = ext_req.wr_data;
      wr_count++;
    end
    #10;
    tcdm_rd_data = tcdm_word;
    ext_rd_data  = ext_word;
  end

  always @(posedge clk) begin
    if (arst_n && term_event) term_count++;
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      errors++;
      $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      finish_run();
    end
  end

  assert property (@(posedge clk) disable iff (!arst_n)
      (reg_req.valid && !reg_req.write) |=> reg_rsp.valid)
    else begin
      errors++;
      $display("Register read response missing in the cycle after the strobe");
    end

  assert property (@(posedge clk) disable iff (!arst_n) term_event |=> !term_event)
    else begin
      errors++;
      $display("Completion event lasted longer than one cycle");
    end

  // An idle DMA must leave both memories alone
  assert property (@(posedge clk) disable iff (!arst_n) !busy |->
      !(tcdm_req.rd_valid || tcdm_req.wr_valid || ext_req.rd_valid || ext_req.wr_valid))
    else begin
      errors++;
      $display("Memory access seen while the DMA reports idle");
    end

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin
    logic [31:0] val;
    logic [31:0] wdat;
    logic [31:0] gap_ref [128];
    logic [31:0] addr;
    int          next_id;
    int          terms;
    int          writes_before;
    int          hits;
    reg_req      = '0;
    tcdm_rd_data = '0;
    ext_rd_data  = '0;
    arst_n       = 1'b0;
    next_id      = 0;
    terms        = 0;
    preload(1'b0, EXT_A, 16);
    preload(1'b1, TCDM_A, 16);
    preload(1'b1, TCDM_B, 64);
    preload(1'b0, EXT_B, 128);
    repeat (3) @(posedge clk);
    #10;
    arst_n = 1'b1;
    expect_eq("term_event_o", 32'(term_event), 0);
    expect_eq("busy_o", 32'(busy), 0);
    expect_eq("reg_rsp_o.valid", 32'(reg_rsp.valid), 0);
    expect_eq("memory strobes", 32'({tcdm_req.rd_valid, tcdm_req.wr_valid,
                                     ext_req.rd_valid, ext_req.wr_valid}), 0);
    reg_read(REG_DONE_ID, val);
    expect_eq("done id after reset", val, 0);

    // Register write and read back
    for (int r = 0; r < 7; r++) begin
      rand_word(wdat);
      reg_write(REG_IDX_W'(r), wdat);
      reg_read(REG_IDX_W'(r), val);
      expect_eq("descriptor register", val, wdat);
    end
    reg_read(REG_STATUS, val);
    expect_eq("status when idle", val, 0);

    // 1D copy from external memory to TCDM
    set_desc(EXT_A, TCDM_A, 16, 0, 0, 0, 0);
    next_id++;
    reg_read(REG_NEXT_ID, val);
    expect_eq("launch id", val, 32'(next_id));
    terms++;
    wait_terms(terms);
    for (int i = 0; i < 16; i++) begin
      expect_eq("tcdm dst word", mem_word(1'b1, TCDM_A + 32'(4 * i)),
                mem_word(1'b0, EXT_A + 32'(4 * i)));
    end

    // 2D copy from TCDM to external memory with untouched gaps
    for (int i = 0; i < 128; i++) gap_ref[i] = mem_word(1'b0, EXT_B + 32'(4 * i));
    set_desc(TCDM_B, EXT_B, 8, 64, 128, 4, 1);
    next_id++;
    reg_read(REG_NEXT_ID, val);
    expect_eq("launch id", val, 32'(next_id));
    terms++;
    wait_terms(terms);
    for (int r = 0; r < 4; r++) begin
      for (int w = 0; w < 32; w++) begin
        addr = EXT_B + 32'(r * 128 + w * 4);
        if (w < 8) begin
          expect_eq("ext dst word", mem_word(1'b0, addr),
                    mem_word(1'b1, TCDM_B + 32'(r * 64 + w * 4)));
        end else begin
          expect_eq("ext gap word", mem_word(1'b0, addr), gap_ref[r * 32 + w]);
        end
      end
    end

    // Back to back launches and completion count
    set_desc(EXT_A, EXT_A + 32'h2000, 4, 0, 0, 0, 0);
    for (int k = 0; k < 3; k++) begin
      next_id++;
      reg_read(REG_NEXT_ID, val);
      expect_eq("launch id", val, 32'(next_id));
    end
    terms += 3;
    wait_terms(terms);
    expect_eq("busy_o after transfers", 32'(busy), 0);
    reg_read(REG_DONE_ID, val);
    expect_eq("done id", val, 32'(next_id));
    reg_read(REG_STATUS, val);
    expect_eq("status after transfers", val, 0);

    // Zero-length burst followed by a 2D transfer without reps
    writes_before = wr_count;
    set_desc(EXT_A, TCDM_C, 0, 0, 0, 0, 0);
    next_id++;
    reg_read(REG_NEXT_ID, val);
    expect_eq("launch id", val, 32'(next_id));
    terms++;
    wait_terms(terms);
    reg_write(REG_LEN, 8);
    reg_write(REG_CONF, 1);
    next_id++;
    reg_read(REG_NEXT_ID, val);
    expect_eq("launch id", val, 32'(next_id));
    terms++;
    wait_terms(terms);
    expect_eq("memory writes", 32'(wr_count), 32'(writes_before));

    // Midend takes one and the queue holds four so the sixth launch is refused
    set_desc(EXT_D, EXT_C, 64, 0, 0, 0, 0);
    for (int k = 0; k < 6; k++) begin
      reg_write(REG_DST, EXT_C + 32'(k * 4096));
      reg_read(REG_NEXT_ID, val);
      if (k < 5) begin
        next_id++;
        expect_eq("launch id", val, 32'(next_id));
      end else begin
        expect_eq("launch id when queue full", val, 0);
      end
    end
    terms += 5;
    wait_terms(terms);
    expect_eq("busy_o", 32'(busy), 0);
    for (int k = 0; k < 5; k++) begin
      expect_eq("long copy first word", mem_word(1'b0, EXT_C + 32'(k * 4096)),
                mem_word(1'b0, EXT_D));
      expect_eq("long copy last word", mem_word(1'b0, EXT_C + 32'(k * 4096 + 252)),
                mem_word(1'b0, EXT_D + 32'd252));
    end
    hits = 0;
    for (int i = 0; i < 64; i++) begin
      if (ext_mem.exists(EXT_C + 32'(5 * 4096 + 4 * i))) hits++;
    end
    expect_eq("refused descriptor writes", 32'(hits), 0);
    reg_read(REG_DONE_ID, val);
    expect_eq("done id", val, 32'(next_id));
    expect_eq("completion events", 32'(term_count), 32'(terms));
    finish_run();
  end

endmodule

/* project.f */
dma_pkg.sv
dma_reg_frontend.sv
dma_req_queue.sv
dma_twod_midend.sv
dma_copy_backend.sv
dma_addr_decoder.sv
dma_top.sv
tb_dma_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DMA testbench with Verilator, pass or fail comes from the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_dma_top \
  -o tb_dma_top > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/tb_dma_top > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see $SIM_LOG"
  exit 1
fi

if grep -q "^TEST OK$" "$SIM_LOG"; then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation failed, see $SIM_LOG"
exit 1
